// ==== core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path width
`define CORE_XLEN 32

// General register file
`define CORE_REG_COUNT 32
`define CORE_REG_AW 5

`endif

// ==== core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

	// Shift amount covers every bit position of a data word
	typedef logic [$clog2(`CORE_XLEN)-1:0] shamt_t;

	// Operation classes seen by the execute stage
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_nor  = 4'd5,
		op_slt  = 4'd6,
		op_sltu = 4'd7,
		op_sll  = 4'd8,
		op_srl  = 4'd9,
		op_sra  = 4'd10,
		op_lui  = 4'd11
	} alu_op_e;

	// Decoded micro-op
	typedef struct packed {
		alu_op_e                 op;
		logic [`CORE_REG_AW-1:0] rs;
		logic [`CORE_REG_AW-1:0] rt;
		logic [`CORE_REG_AW-1:0] rd;
		logic                    use_imm;
		logic [`CORE_XLEN-1:0]   imm;
		logic                    var_shift;
		shamt_t                  shamt;
	} uop_t;

endpackage

// ==== core_ifs.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

////////////////////////////////////////
// Decode to operand stage
////////////////////////////////////////
interface issue_if;
	logic           valid;
	core_pkg::uop_t uop;

	modport source (output valid, output uop);
	modport sink (input valid, input uop);
endinterface

////////////////////////////////////////
// Operand stage to execute
////////////////////////////////////////
interface exec_if;
	logic                    valid;
	core_pkg::alu_op_e       op;
	logic [`CORE_XLEN-1:0]   a;
	// Already holds the immediate for I-type
	logic [`CORE_XLEN-1:0]   b;
	core_pkg::shamt_t        shamt;
	logic [`CORE_REG_AW-1:0] dst;

	modport source (output valid, output op, output a, output b, output shamt, output dst);
	modport sink (input valid, input op, input a, input b, input shamt, input dst);
endinterface

////////////////////////////////////////
// Result bypass back to operand stage
////////////////////////////////////////
interface fwd_if;
	// Combinational result of the op in EX
	logic                    ex_valid;
	logic [`CORE_REG_AW-1:0] ex_addr;
	logic [`CORE_XLEN-1:0]   ex_data;
	// EX/WB register that also writes the register file
	logic                    wb_valid;
	logic [`CORE_REG_AW-1:0] wb_addr;
	logic [`CORE_XLEN-1:0]   wb_data;

	modport source (
		output ex_valid, output ex_addr, output ex_data,
		output wb_valid, output wb_addr, output wb_data
	);
	modport sink (
		input ex_valid, input ex_addr, input ex_data,
		input wb_valid, input wb_addr, input wb_data
	);
endinterface

// ==== instr_decode.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module instr_decode (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        instr_valid_i,
	input  logic [31:0] instr_i,
	issue_if.source     iss
);

	logic [5:0]            opcode;
	logic [5:0]            funct;
	logic [`CORE_XLEN-1:0] imm_sext;
	logic [`CORE_XLEN-1:0] imm_zext;
	logic [`CORE_XLEN-1:0] imm_upper;
	logic                  known;
	core_pkg::uop_t        uop_d;

	assign opcode    = instr_i[31:26];
	assign funct     = instr_i[5:0];
	assign imm_sext  = {{(`CORE_XLEN-16){instr_i[15]}}, instr_i[15:0]};
	assign imm_zext  = {{(`CORE_XLEN-16){1'b0}}, instr_i[15:0]};
	assign imm_upper = {instr_i[15:0], {(`CORE_XLEN-16){1'b0}}};

	////////////////////////////////////////
	// Opcode and funct decode
	////////////////////////////////////////
	always_comb begin
		uop_d       = '0;
		uop_d.op    = core_pkg::op_add;
		uop_d.rs    = instr_i[25:21];
		uop_d.rt    = instr_i[20:16];
		uop_d.rd    = instr_i[15:11];
		uop_d.shamt = instr_i[10:6];
		known       = 1'b1;
		if (opcode == 6'h00) begin
			// SPECIAL group writes rd
			case (funct)
				6'h00: uop_d.op = core_pkg::op_sll;
				6'h02: uop_d.op = core_pkg::op_srl;
				6'h03: uop_d.op = core_pkg::op_sra;
				6'h04: begin
					uop_d.op        = core_pkg::op_sll;
					uop_d.var_shift = 1'b1;
				end
				6'h06: begin
					uop_d.op        = core_pkg::op_srl;
					uop_d.var_shift = 1'b1;
				end
				6'h07: begin
					uop_d.op        = core_pkg::op_sra;
					uop_d.var_shift = 1'b1;
				end
				6'h21: uop_d.op = core_pkg::op_add;
				6'h23: uop_d.op = core_pkg::op_sub;
				6'h24: uop_d.op = core_pkg::op_and;
				6'h25: uop_d.op = core_pkg::op_or;
				6'h26: uop_d.op = core_pkg::op_xor;
				6'h27: uop_d.op = core_pkg::op_nor;
				6'h2a: uop_d.op = core_pkg::op_slt;
				6'h2b: uop_d.op = core_pkg::op_sltu;
				default: known = 1'b0;
			endcase
		end else begin
			// Immediate forms write rt
			uop_d.rd      = instr_i[20:16];
			uop_d.use_imm = 1'b1;
			case (opcode)
				6'h09: begin
					uop_d.op  = core_pkg::op_add;
					uop_d.imm = imm_sext;
				end
				6'h0a: begin
					uop_d.op  = core_pkg::op_slt;
					uop_d.imm = imm_sext;
				end
				6'h0b: begin
					uop_d.op  = core_pkg::op_sltu;
					uop_d.imm = imm_sext;
				end
				6'h0c: begin
					uop_d.op  = core_pkg::op_and;
					uop_d.imm = imm_zext;
				end
				6'h0d: begin
					uop_d.op  = core_pkg::op_or;
					uop_d.imm = imm_zext;
				end
				6'h0e: begin
					uop_d.op  = core_pkg::op_xor;
					uop_d.imm = imm_zext;
				end
				6'h0f: begin
					uop_d.op  = core_pkg::op_lui;
					uop_d.imm = imm_upper;
				end
				default: known = 1'b0;
			endcase
		end
	end

	// Writes to r0 are dropped in the decode register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			iss.valid <= 1'b0;
			iss.uop   <= '0;
		end else begin
			iss.valid <= instr_valid_i && known && (uop_d.rd != '0);
			iss.uop   <= uop_d;
		end
	end

	// An r0 destination in the instruction word never issues
	a_no_r0_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
		instr_valid_i && (((opcode == 6'h00) ? instr_i[15:11] : instr_i[20:16]) == '0)
		|=> !iss.valid)
		else $error("decode issued a micro-op that writes r0");

endmodule

// ==== operand_stage.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module operand_stage (
	input  logic   clk,
	input  logic   arst_n_i,
	issue_if.sink  iss,
	fwd_if.sink    fwd,
	exec_if.source exe
);

	logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];
	logic [`CORE_XLEN-1:0] a_val;
	logic [`CORE_XLEN-1:0] rt_val;
	logic [`CORE_XLEN-1:0] b_val;
	core_pkg::shamt_t      shamt_val;

	// Newest value wins with EX before WB before the file
	function automatic logic [`CORE_XLEN-1:0] read_operand(
		input logic [`CORE_REG_AW-1:0] addr
	);
		logic [`CORE_XLEN-1:0] val;
		if (fwd.ex_valid && (fwd.ex_addr == addr)) begin
			val = fwd.ex_data;
		end else if (fwd.wb_valid && (fwd.wb_addr == addr)) begin
			val = fwd.wb_data;
		end else if (addr == '0) begin
			val = '0;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (fwd.wb_valid) begin
			regs[fwd.wb_addr] <= fwd.wb_data;
		end
	end

	////////////////////////////////////////
	// Operand select
	////////////////////////////////////////
	always_comb begin
		a_val     = read_operand(iss.uop.rs);
		rt_val    = read_operand(iss.uop.rt);
		b_val     = iss.uop.use_imm ? iss.uop.imm : rt_val;
		// Variable shifts take the low bits of rs
		shamt_val = iss.uop.var_shift ? a_val[$bits(core_pkg::shamt_t)-1:0] : iss.uop.shamt;
	end

	// ID/EX register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exe.valid <= 1'b0;
			exe.op    <= core_pkg::op_add;
			exe.a     <= '0;
			exe.b     <= '0;
			exe.shamt <= '0;
			exe.dst   <= '0;
		end else begin
			exe.valid <= iss.valid;
			exe.op    <= iss.uop.op;
			exe.a     <= a_val;
			exe.b     <= b_val;
			exe.shamt <= shamt_val;
			exe.dst   <= iss.uop.rd;
		end
	end

	a_known_operands: assert property (@(posedge clk) disable iff (!arst_n_i)
		exe.valid |-> !$isunknown({exe.a, exe.b, exe.shamt}))
		else $error("valid op left operand stage with unknown operands");

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module execute_stage (
	input  logic                    clk,
	input  logic                    arst_n_i,
	exec_if.sink                    exe,
	fwd_if.source                   fwd,
	output logic                    wb_valid_o,
	output logic [`CORE_REG_AW-1:0] wb_addr_o,
	output logic [`CORE_XLEN-1:0]   wb_data_o
);

	logic [`CORE_XLEN-1:0]   alu_res;
	logic [`CORE_XLEN-1:0]   shift_res;
	logic [`CORE_XLEN-1:0]   result;
	logic                    is_shift;
	logic                    wb_valid_q;
	logic [`CORE_REG_AW-1:0] wb_addr_q;
	logic [`CORE_XLEN-1:0]   wb_data_q;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (exe.op)
			core_pkg::op_add:  alu_res = exe.a + exe.b;
			core_pkg::op_sub:  alu_res = exe.a - exe.b;
			core_pkg::op_and:  alu_res = exe.a & exe.b;
			core_pkg::op_or:   alu_res = exe.a | exe.b;
			core_pkg::op_xor:  alu_res = exe.a ^ exe.b;
			core_pkg::op_nor:  alu_res = ~(exe.a | exe.b);
			core_pkg::op_slt:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(exe.a) < $signed(exe.b)};
			core_pkg::op_sltu: alu_res = {{(`CORE_XLEN-1){1'b0}}, exe.a < exe.b};
			// Immediate is already in the upper half
			core_pkg::op_lui:  alu_res = exe.b;
			default:           alu_res = '0;
		endcase
	end

	////////////////////////////////////////
	// Barrel shifter
	////////////////////////////////////////
	always_comb begin
		case (exe.op)
			core_pkg::op_sll: shift_res = exe.b << exe.shamt;
			core_pkg::op_srl: shift_res = exe.b >> exe.shamt;
			core_pkg::op_sra: shift_res = $signed(exe.b) >>> exe.shamt;
			default:          shift_res = '0;
		endcase
	end

	assign is_shift = exe.op inside {core_pkg::op_sll, core_pkg::op_srl, core_pkg::op_sra};
	assign result   = is_shift ? shift_res : alu_res;

	// Same-cycle bypass
	assign fwd.ex_valid = exe.valid;
	assign fwd.ex_addr  = exe.dst;
	assign fwd.ex_data  = result;

	// EX/WB register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_q <= 1'b0;
			wb_addr_q  <= '0;
			wb_data_q  <= '0;
		end else begin
			wb_valid_q <= exe.valid;
			wb_addr_q  <= exe.dst;
			wb_data_q  <= result;
		end
	end

	assign fwd.wb_valid = wb_valid_q;
	assign fwd.wb_addr  = wb_addr_q;
	assign fwd.wb_data  = wb_data_q;

	assign wb_valid_o = wb_valid_q;
	assign wb_addr_o  = wb_addr_q;
	assign wb_data_o  = wb_data_q;

	a_wb_not_r0: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_valid_o |-> (wb_addr_o != '0))
		else $error("writeback targets r0");

endmodule

// ==== int_pipe_top.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module int_pipe_top (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    instr_valid_i,
	input  logic [31:0]             instr_i,
	output logic                    wb_valid_o,
	output logic [`CORE_REG_AW-1:0] wb_addr_o,
	output logic [`CORE_XLEN-1:0]   wb_data_o
);

	////////////////////////////////////////
	// Stage links
	////////////////////////////////////////
	issue_if i_issue ();
	exec_if  i_exec ();
	fwd_if   i_fwd ();

	////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////
	instr_decode i_decode (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.iss           (i_issue.source)
	);

	operand_stage i_operand (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.iss      (i_issue.sink),
		.fwd      (i_fwd.sink),
		.exe      (i_exec.source)
	);

	execute_stage i_execute (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.exe        (i_exec.sink),
		.fwd        (i_fwd.source),
		.wb_valid_o (wb_valid_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

// ==== tb_int_pipe.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module tb_int_pipe;

	// One expected writeback
	typedef struct packed {
		logic [31:0]             due;
		logic [31:0]             idx;
		logic [`CORE_REG_AW-1:0] addr;
		logic [`CORE_XLEN-1:0]   data;
	} wb_exp_t;

	logic                    clk;
	logic                    arst_n_i;
	logic                    instr_valid_i;
	logic [31:0]             instr_i;
	logic                    wb_valid_o;
	logic [`CORE_REG_AW-1:0] wb_addr_o;
	logic [`CORE_XLEN-1:0]   wb_data_o;

	logic [31:0] gold_instr [$];
	logic [31:0] gold_flag [$];
	logic [31:0] gold_addr [$];
	logic [31:0] gold_data [$];
	wb_exp_t     exp_q [$];
	logic [31:0] rng_state;
	int          edge_cnt = 0;
	int          cycle_limit = 1000;

	int_pipe_top i_dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_instr;
		logic [31:0] f_flag;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		fd = $fopen("int_pipe_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the golden file int_pipe_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank and comment lines
				if (line.len() < 2 || line.substr(0, 1) == "//") begin
					continue;
				end
				n = $sscanf(line, "%h %h %h %h", f_instr, f_flag, f_addr, f_data);
				if (n == 4) begin
					gold_instr.push_back(f_instr);
					gold_flag.push_back(f_flag);
					gold_addr.push_back(f_addr);
					gold_data.push_back(f_data);
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////
	// Cycle counter and watchdog
	////////////////////////////////////////
	always @(posedge clk) begin
		edge_cnt++;
		if (edge_cnt > cycle_limit) begin
			abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
		end
	end

	////////////////////////////////////////
	// Writeback checker
	////////////////////////////////////////
	// Outputs are stable at the falling edge after the EX/WB load
	always @(negedge clk) begin
		wb_exp_t head;
		if (exp_q.size() != 0 && exp_q[0].due == edge_cnt) begin
			head = exp_q.pop_front();
			if (wb_valid_o !== 1'b1) begin
				abort_run($sformatf("Golden line %0d expected a writeback but none came",
					head.idx));
			end else begin
				check_value($sformatf("line %0d wb_addr", head.idx), head.addr, wb_addr_o);
				check_value($sformatf("line %0d wb_data", head.idx), head.data, wb_data_o);
			end
		end else if (wb_valid_o !== 1'b0) begin
			abort_run($sformatf("Writeback to r%0d at cycle %0d that no instruction expects",
				wb_addr_o, edge_cnt));
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		int      idle;
		wb_exp_t item;
		rng_state     = 32'd68;
		arst_n_i      = 1'b0;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		load_golden();
		cycle_limit = 16 + 3 * gold_instr.size() + 20;

		repeat (16) @(posedge clk);
		#2;
		arst_n_i = 1'b1;

		foreach (gold_instr[i]) begin
			// Random gaps change the forwarding distance
			rng_state = xorshift32(rng_state);
			idle      = rng_state % 3;
			repeat (idle) begin
				@(posedge clk);
				#2;
				instr_valid_i = 1'b0;
				instr_i       = '0;
			end
			@(posedge clk);
			#2;
			instr_valid_i = 1'b1;
			instr_i       = gold_instr[i];
			// Sampled at the next edge and in EX/WB two edges later
			if (gold_flag[i] != 0) begin
				item.due  = edge_cnt + 3;
				item.idx  = i;
				item.addr = gold_addr[i];
				item.data = gold_data[i];
				exp_q.push_back(item);
			end
		end
		@(posedge clk);
		#2;
		instr_valid_i = 1'b0;
		instr_i       = '0;

		while (exp_q.size() != 0) @(posedge clk);
		// A few more cycles to catch stray writebacks
		repeat (4) @(posedge clk);

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
core_pkg.sv
core_ifs.sv
instr_decode.sv
operand_stage.sv
execute_stage.sv
int_pipe_top.sv
tb_int_pipe.sv

// ==== int_pipe_golden.txt ====
// Columns in hex: instruction word, writeback expected (1 or 0), destination, result data
// Lines without a writeback carry zero destination and data
03df0821 1 01 00000000  // addu  r1, r30, r31
24017fff 1 01 00007fff  // addiu r1, r0, 0x7fff
24028000 1 02 ffff8000  // addiu r2, r0, 0x8000
3c038000 1 03 80000000  // lui   r3, 0x8000
3463ffff 1 03 8000ffff  // ori   r3, r3, 0xffff
00622021 1 04 80007fff  // addu  r4, r3, r2
00222823 1 05 0000ffff  // subu  r5, r1, r2
00013023 1 06 ffff8001  // subu  r6, r0, r1
00663824 1 07 80008001  // and   r7, r3, r6
00224025 1 08 ffffffff  // or    r8, r1, r2
00644826 1 09 00008000  // xor   r9, r3, r4
00295027 1 0a ffff0000  // nor   r10, r1, r9
0041582a 1 0b 00000001  // slt   r11, r2, r1
0041602b 1 0c 00000000  // sltu  r12, r2, r1
284dffff 1 0d 00000001  // slti  r13, r2, -1
2c2e8000 1 0e 00000001  // sltiu r14, r1, 0x8000
304f8f0f 1 0f 00008000  // andi  r15, r2, 0x8f0f
39101234 1 10 ffffedcb  // xori  r16, r8, 0x1234
00038900 1 11 000ffff0  // sll   r17, r3, 4
00039202 1 12 008000ff  // srl   r18, r3, 8
00039a03 1 13 ff8000ff  // sra   r19, r3, 8
24140024 1 14 00000024  // addiu r20, r0, 0x24
0288a804 1 15 fffffff0  // sllv  r21, r8, r20
0283b006 1 16 08000fff  // srlv  r22, r3, r20
0283b807 1 17 f8000fff  // srav  r23, r3, r20
24180001 1 18 00000001  // addiu r24, r0, 1
27180002 1 18 00000003  // addiu r24, r24, 2
0318c821 1 19 00000006  // addu  r25, r24, r24
0338d023 1 1a 00000003  // subu  r26, r25, r24
24005555 0 00 00000000  // addiu r0, r0, 0x5555
00221801 0 00 00000000  // unknown funct
20030001 0 00 00000000  // addi is not supported
0000d821 1 1b 00000000  // addu  r27, r0, r0
0060e025 1 1c 8000ffff  // or    r28, r3, r0
